// File: design/sdram_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the sdram controller
// command encodings and sdram timing constants
// mode register word and init timing
// bus request, pin bundle and row state types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sdram_pkg;

	// bit order is {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		LOAD_MODE    = 4'b0000,
		AUTO_REFRESH = 4'b0001,
		PRECHARGE    = 4'b0010,
		ACTIVE       = 4'b0011,
		WRITE        = 4'b0100,
		READ         = 4'b0101,
		NOP          = 4'b0111,
		INHIBIT      = 4'b1111
	} sd_cmd_e;

	localparam int RASCAS_DELAY    = 2;	// tRCD
	localparam int PRECHARGE_DELAY = 2;	// tRP
	localparam int CAS_LATENCY     = 2;
	localparam int RFC_DELAY       = 7;	// auto refresh to next command

	localparam logic [2:0] BURST_LENGTH_CODE  = 3'b011;	// 8 beats, sequential
	localparam logic       WRITE_BURST_SINGLE = 1'b1;	// writes hit one location

	// reserved, write burst mode, op mode, cas latency, burst type, length
	localparam logic [12:0] MODE_WORD = {3'b000, WRITE_BURST_SINGLE, 2'b00,
		3'(CAS_LATENCY), 1'b0, BURST_LENGTH_CODE};

	localparam int INIT_WAIT      = 64;	// short power-up wait for simulation
	localparam int MRS_GAP        = 16;	// cycles between init steps
	localparam int REFRESH_PERIOD = 390;

	// address split over the 24-bit word address
	// bank 22..21, row 20..9, column {23, 8..2, half}, tag 23..4
	localparam int ROW_W  = 12;
	localparam int COL_W  = 9;
	localparam int BANK_W = 2;
	localparam int TAG_W  = 20;

	typedef struct packed {
		logic [23:0] adr;
		logic [31:0] wdata;
		logic [3:0]  sel;
		logic        we;
		logic        burst;	// wrapping 4-word read
	} bus_req_t;

	typedef struct packed {
		sd_cmd_e           cmd;
		logic [BANK_W-1:0] ba;
		logic [12:0]       addr;
		logic [1:0]        dqm;
	} sd_pins_t;

	typedef enum logic [1:0] {
		ROW_CLOSED = 2'd0,
		ROW_HIT    = 2'd1,
		ROW_MISS   = 2'd2
	} row_state_e;

endpackage

// File: design/sdram_row_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// open row table, one entry per bank
// classifies a request as closed, hit or miss
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_row_tracker import sdram_pkg::*; (
	input  logic              sd_clk,
	input  logic              reset,
	input  logic [BANK_W-1:0] bank,
	input  logic [ROW_W-1:0]  row,
	input  logic              open_en,
	input  logic              close_all,
	output row_state_e        row_state
);

	logic [ROW_W-1:0]       open_row [2**BANK_W];
	logic [2**BANK_W-1:0]   bank_open;

	always_comb begin
		if (!bank_open[bank])
			row_state = ROW_CLOSED;
		else if (open_row[bank] == row)
			row_state = ROW_HIT;
		else
			row_state = ROW_MISS;	// needs precharge first
	end

	always_ff @(posedge sd_clk) begin
		if (reset)
			bank_open <= '0;
		else if (close_all)
			bank_open <= '0;	// precharge-all before refresh
		else if (open_en)
			bank_open[bank] <= 1'b1;
	end

	// row of the last activate per bank
	always_ff @(posedge sd_clk) begin
		if (open_en)
			open_row[bank] <= row;
	end

	a_open_vs_close: assert property (@(posedge sd_clk) disable iff (reset)
		!(open_en && close_all));

endmodule

// File: design/sdram_refresh_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// auto refresh interval counter
// request held until the sequencer acknowledges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_refresh_timer import sdram_pkg::*; (
	input  logic sd_clk,
	input  logic reset,
	input  logic enable,	// controller ready
	input  logic refresh_ack,
	output logic refresh_req
);

	logic [$clog2(REFRESH_PERIOD)-1:0] count;

	always_ff @(posedge sd_clk) begin
		if (reset) begin
			count       <= '0;
			refresh_req <= 1'b0;
		end else if (refresh_ack) begin
			count       <= '0;	// interval restarts at the refresh
			refresh_req <= 1'b0;
		end else if (enable && !refresh_req) begin
			if (count == REFRESH_PERIOD - 1)
				refresh_req <= 1'b1;	// counter parks here until ack
			else
				count <= count + 1'b1;
		end
	end

	// sequencer only acknowledges a pending request
	a_ack_needs_req: assert property (@(posedge sd_clk) disable iff (reset)
		refresh_ack |-> refresh_req);

endmodule

// File: design/sdram_line_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4-word read line buffer
// filled from sd_dq one half-word per beat
// tag compare for hits, single or wrapping burst output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_line_buffer import sdram_pkg::*; (
	input  logic             sd_clk,
	input  logic             reset,
	input  logic [15:0]      dq_in,
	input  logic             fill_en,
	input  logic [2:0]       fill_beat,
	input  logic [TAG_W-1:0] fill_tag,
	input  logic             invalidate,
	input  logic [23:0]      adr,
	input  logic             burst,
	input  logic             done,
	output logic             line_hit,
	output logic [31:0]      rdata,
	output logic             ack
);

	logic [15:0]      store [8];	// beat n holds half-word n of the line
	logic [TAG_W-1:0] tag;
	logic             valid;
	logic [1:0]       word_idx;	// next word of a burst
	logic [1:0]       words_left;

	function automatic logic [31:0] word_at(input logic [1:0] w);
		return {store[{w, 1'b1}], store[{w, 1'b0}]};
	endfunction

	assign line_hit = valid && (tag == adr[23:4]);

	always_ff @(posedge sd_clk) begin
		if (fill_en)
			store[fill_beat] <= dq_in;
		if (fill_en && fill_beat == 3'd7)
			tag <= fill_tag;
	end

	always_ff @(posedge sd_clk) begin
		if (reset || invalidate)
			valid <= 1'b0;
		else if (fill_en && fill_beat == 3'd7)
			valid <= 1'b1;	// last beat in
	end

	always_ff @(posedge sd_clk) begin
		if (reset) begin
			ack        <= 1'b0;
			word_idx   <= '0;
			words_left <= '0;
		end else if (done) begin
			ack        <= 1'b1;
			rdata      <= word_at(adr[3:2]);	// requested word first
			word_idx   <= adr[3:2] + 2'd1;
			words_left <= burst ? 2'd3 : 2'd0;
		end else if (words_left != 2'd0) begin
			ack        <= 1'b1;	// no gap inside a burst
			rdata      <= word_at(word_idx);
			word_idx   <= word_idx + 2'd1;	// wraps within the line
			words_left <= words_left - 2'd1;
		end else begin
			ack <= 1'b0;
		end
	end

	a_no_fill_in_burst: assert property (@(posedge sd_clk) disable iff (reset)
		!(fill_en && words_left != 2'd0));

endmodule

// File: design/sdram_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sdram control state machine
// power-up sequence, auto refresh, precharge and activate
// two-beat word writes, 8-beat line reads into the buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_sequencer import sdram_pkg::*; (
	input  logic             sd_clk,
	input  logic             reset,
	input  bus_req_t         req,
	input  logic             req_valid,
	input  row_state_e       row_state,
	input  logic             line_hit,
	input  logic             refresh_req,
	output sd_pins_t         pins,
	output logic             drive_dq,
	output logic [15:0]      wdata_half,
	output logic             fill_en,
	output logic [2:0]       fill_beat,
	output logic [TAG_W-1:0] fill_tag,
	output logic             invalidate,
	output logic             open_en,
	output logic             close_all,
	output logic             refresh_ack,
	output logic             done,
	output logic             sd_ready
);

	typedef enum logic [3:0] {
		S_INIT, S_IDLE, S_RFSH, S_PRE, S_RCD, S_COL1, S_RDWAIT, S_FILL, S_DRAIN
	} state_e;

	state_e state;
	logic [7:0] cnt;	// shared phase counter

	logic [BANK_W-1:0] bank;
	logic [ROW_W-1:0]  row;
	logic [COL_W-1:0]  col_lo, col_hi, col_line;

	assign bank     = req.adr[22:21];
	assign row      = req.adr[20:9];
	assign col_lo   = {req.adr[23], req.adr[8:2], 1'b0};	// low half-word
	assign col_hi   = {req.adr[23], req.adr[8:2], 1'b1};
	assign col_line = {req.adr[23], req.adr[8:4], 3'b000};	// burst starts at line base

	always_ff @(posedge sd_clk) begin
		// strobes drop back unless a state sets them
		pins.cmd    <= NOP;
		pins.dqm    <= 2'b00;
		drive_dq    <= 1'b0;
		open_en     <= 1'b0;
		close_all   <= 1'b0;
		refresh_ack <= 1'b0;
		invalidate  <= 1'b0;
		done        <= 1'b0;
		if (reset) begin
			state     <= S_INIT;
			cnt       <= '0;
			pins.cmd  <= INHIBIT;
			pins.ba   <= '0;
			pins.addr <= '0;
			sd_ready  <= 1'b0;
			fill_en   <= 1'b0;
			fill_beat <= '0;
		end else begin
			case (state)
			S_INIT: begin
				cnt <= cnt + 8'd1;
				if (cnt == INIT_WAIT) begin
					pins.cmd      <= PRECHARGE;
					pins.addr[10] <= 1'b1;	// all banks
				end
				if (cnt == INIT_WAIT + MRS_GAP || cnt == INIT_WAIT + 2 * MRS_GAP) begin
					pins.cmd  <= LOAD_MODE;
					pins.addr <= MODE_WORD;
				end
				if (cnt == INIT_WAIT + 3 * MRS_GAP) begin
					sd_ready <= 1'b1;
					state    <= S_IDLE;
				end
			end
			S_IDLE: begin
				if (refresh_req) begin	// refresh wins over the bus
					pins.cmd      <= PRECHARGE;
					pins.addr[10] <= 1'b1;
					close_all     <= 1'b1;
					refresh_ack   <= 1'b1;
					cnt           <= '0;
					state         <= S_RFSH;
				end else if (req_valid) begin
					if (!req.we && line_hit) begin
						done  <= 1'b1;	// served from the line buffer
						state <= S_DRAIN;
					end else begin
						invalidate <= 1'b1;	// buffer refilled or stale after write
						fill_tag   <= req.adr[23:4];
						pins.ba    <= bank;
						cnt        <= '0;
						state      <= S_RCD;
						case (row_state)
						ROW_CLOSED: begin
							pins.cmd  <= ACTIVE;
							pins.addr <= 13'(row);
							open_en   <= 1'b1;
						end
						ROW_HIT: cnt <= 8'(RASCAS_DELAY - 1);	// column cmd next cycle
						default: begin	// other row open in this bank
							pins.cmd      <= PRECHARGE;
							pins.addr[10] <= 1'b0;
							state         <= S_PRE;
						end
						endcase
					end
				end
			end
			S_RFSH: begin
				cnt <= cnt + 8'd1;
				if (cnt == 8'd2)
					pins.cmd <= AUTO_REFRESH;	// third cycle after precharge-all
				if (cnt == 8'(2 + RFC_DELAY))
					state <= S_IDLE;
			end
			S_PRE: begin
				cnt <= cnt + 8'd1;
				if (cnt == PRECHARGE_DELAY - 1) begin
					pins.cmd  <= ACTIVE;
					pins.addr <= 13'(row);
					open_en   <= 1'b1;
					cnt       <= '0;
					state     <= S_RCD;
				end
			end
			S_RCD: begin
				cnt <= cnt + 8'd1;
				if (cnt == RASCAS_DELAY - 1) begin
					pins.ba <= bank;
					if (req.we) begin
						pins.cmd   <= WRITE;
						pins.addr  <= 13'(col_lo);	// a10 low, no auto precharge
						pins.dqm   <= ~req.sel[1:0];
						wdata_half <= req.wdata[15:0];
						drive_dq   <= 1'b1;
						state      <= S_COL1;
					end else begin
						pins.cmd  <= READ;
						pins.addr <= 13'(col_line);
						cnt       <= '0;
						state     <= S_RDWAIT;
					end
				end
			end
			S_COL1: begin	// upper half of the word
				pins.cmd   <= WRITE;
				pins.addr  <= 13'(col_hi);
				pins.dqm   <= ~req.sel[3:2];
				wdata_half <= req.wdata[31:16];
				drive_dq   <= 1'b1;
				done       <= 1'b1;
				state      <= S_DRAIN;
			end
			S_RDWAIT: begin
				// first beat is sampled CAS_LATENCY+1 edges after READ is registered
				cnt <= cnt + 8'd1;
				if (cnt == CAS_LATENCY - 1) begin
					fill_en   <= 1'b1;
					fill_beat <= 3'd0;
					state     <= S_FILL;
				end
			end
			S_FILL: begin
				if (fill_beat == 3'd7) begin
					fill_en <= 1'b0;
					done    <= 1'b1;
					state   <= S_DRAIN;
				end else begin
					fill_beat <= fill_beat + 3'd1;
				end
			end
			S_DRAIN: if (!req_valid) state <= S_IDLE;	// master drops stb after its ack
			default: state <= S_IDLE;
			endcase
		end
	end

	// nothing may open a row within tRFC of an auto refresh
	a_no_active_in_rfc: assert property (@(posedge sd_clk) disable iff (reset)
		pins.cmd == AUTO_REFRESH |=> (pins.cmd != ACTIVE) [*RFC_DELAY]);

	a_dq_only_on_write: assert property (@(posedge sd_clk) disable iff (reset)
		drive_dq |-> pins.cmd == WRITE);

	a_done_pulse: assert property (@(posedge sd_clk) disable iff (reset)
		done |=> !done);

endmodule

// File: design/sdram_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sdram controller top level
// sequencer, row tracker, refresh timer and line buffer
// bus request bundle and tri-state data pad
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_top import sdram_pkg::*; (
	input  logic              sd_clk,
	input  logic              reset,
	output logic              sd_cke,
	output logic              sd_cs_n,
	output logic              sd_ras_n,
	output logic              sd_cas_n,
	output logic              sd_we_n,
	output logic [BANK_W-1:0] sd_ba,
	output logic [12:0]       sd_addr,
	output logic [1:0]        sd_dqm,
	inout  wire  [15:0]       sd_dq,
	output logic              sd_ready,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [23:0]       wb_adr,	// word address
	input  logic [3:0]        wb_sel,
	input  logic [2:0]        wb_cti,
	input  logic [31:0]       wb_wdata,
	output logic [31:0]       wb_rdata,
	output logic              wb_ack
);

	bus_req_t         req;
	sd_pins_t         pins;
	row_state_e       row_state;
	logic             req_valid, line_hit, refresh_req, refresh_ack;
	logic             drive_dq, fill_en, invalidate, open_en, close_all, done;
	logic [15:0]      wdata_half;
	logic [2:0]       fill_beat;
	logic [TAG_W-1:0] fill_tag;

	assign req_valid = wb_cyc && wb_stb;
	// cti 010 is an incrementing burst, only meaningful for reads here
	assign req = '{adr: wb_adr, wdata: wb_wdata, sel: wb_sel, we: wb_we,
		burst: (wb_cti == 3'b010) && !wb_we};

	sdram_sequencer u_seq (
		.sd_clk, .reset, .req, .req_valid, .row_state, .line_hit, .refresh_req,
		.pins, .drive_dq, .wdata_half, .fill_en, .fill_beat, .fill_tag,
		.invalidate, .open_en, .close_all, .refresh_ack, .done, .sd_ready
	);

	sdram_row_tracker u_rows (
		.sd_clk, .reset, .bank(req.adr[22:21]), .row(req.adr[20:9]),
		.open_en, .close_all, .row_state
	);

	sdram_refresh_timer u_rfsh (
		.sd_clk, .reset, .enable(sd_ready), .refresh_ack, .refresh_req
	);

	sdram_line_buffer u_line (
		.sd_clk, .reset, .dq_in(sd_dq), .fill_en, .fill_beat, .fill_tag, .invalidate,
		.adr(req.adr), .burst(req.burst), .done, .line_hit, .rdata(wb_rdata), .ack(wb_ack)
	);

	assign {sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n} = pins.cmd;
	assign sd_ba   = pins.ba;
	assign sd_addr = pins.addr;
	assign sd_dqm  = pins.dqm;
	assign sd_cke  = 1'b1;	// no power-down
	assign sd_dq   = drive_dq ? wdata_half : 16'hzzzz;	// only in WRITE cycles

endmodule

// File: tb/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// 4 ns clock, reset held high for 10 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock (
	output logic sd_clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 2;
	localparam int RESET_CYCLES = 10;

	initial begin
		sd_clk = 1'b0;
		forever #HALF_PERIOD sd_clk = ~sd_clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge sd_clk);
		@(negedge sd_clk);
		reset = 1'b0;	// released away from the sampling edge
	end

endmodule

// File: tb/sdram_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral sdram for the testbench
// init order, mode word, clock enable and bank state checks
// refresh count
// cas latency 2 reads of 8 beats, single masked writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_model import sdram_pkg::*; (
	input  logic        sd_clk,
	input  logic        reset,	// controller reset, pins not yet defined
	input  logic        cke,
	input  logic        cs_n,
	input  logic        ras_n,
	input  logic        cas_n,
	input  logic        we_n,
	input  logic [1:0]  ba,
	input  logic [12:0] addr,
	input  logic [1:0]  dqm,
	inout  wire  [15:0] dq,
	output logic        init_done,
	output int          error_count,
	output int          refresh_count
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] mem [logic [22:0]];	// key is {bank, row, column}
	logic [3:0]  bank_open;
	logic [11:0] open_row [4];
	int          init_step;	// 0 precharge, 1 and 2 mode loads, 3 done
	sd_cmd_e     cmd;
	logic        rd_active, oe;
	logic [2:0]  rd_beat;
	logic [22:0] rd_base, wkey;
	logic [15:0] dq_out, old;

	assign cmd       = sd_cmd_e'({cs_n, ras_n, cas_n, we_n});
	assign dq        = oe ? dq_out : 16'hzzzz;
	assign init_done = (init_step == 3);

	// unwritten locations read back a pattern of the full key
	function automatic logic [15:0] fill_value(input logic [22:0] key);
		return key[15:0] ^ {key[22:16], key[22:14]};
	endfunction

	function automatic logic [15:0] read_half(input logic [22:0] key);
		return mem.exists(key) ? mem[key] : fill_value(key);
	endfunction

	task automatic report_fault(input string what);
		$display("%0t model: %s", $time, what);
		error_count++;
	endtask

	initial begin
		error_count   = 0;
		refresh_count = 0;
		init_step     = 0;
		bank_open     = '0;
		rd_active     = 1'b0;
		oe            = 1'b0;
	end

	always @(posedge sd_clk) begin
		// beat k goes out one edge before the controller samples it
		if (rd_active) begin
			oe      <= 1'b1;
			dq_out  <= read_half({rd_base[22:3], rd_beat});
			rd_beat <= rd_beat + 3'd1;
			if (rd_beat == 3'd7)
				rd_active <= 1'b0;
		end else begin
			oe <= 1'b0;
		end
		if (!reset) begin
			if (cke !== 1'b1)
				report_fault("clock enable dropped, power-down is not modeled");
			if (cmd != NOP && cmd != INHIBIT && cmd != PRECHARGE && cmd != LOAD_MODE
					&& init_step != 3)
				report_fault("command issued before init completed");
			case (cmd)
			INHIBIT, NOP: ;
			PRECHARGE: begin
				if (init_step == 0) begin
					if (addr[10])
						init_step <= 1;
					else
						report_fault("init did not start with precharge-all");
				end else if (init_step != 3) begin
					report_fault("extra precharge during mode register loads");
				end
				if (addr[10])
					bank_open <= '0;
				else
					bank_open[ba] <= 1'b0;
			end
			LOAD_MODE: begin
				if (init_step == 1 || init_step == 2) begin
					// single writes, cas latency 2, sequential burst of 8
					if (addr != 13'b000_1_00_010_0_011)
						report_fault("LOAD_MODE with a wrong mode word");
					init_step <= init_step + 1;
				end else begin
					report_fault("LOAD_MODE outside the init sequence");
				end
			end
			ACTIVE: begin
				if (bank_open[ba])
					report_fault("ACTIVE on a bank that is already open");
				bank_open[ba] <= 1'b1;
				open_row[ba]  <= addr[11:0];
			end
			READ: begin
				if (!bank_open[ba])
					report_fault("READ to a bank that is not open");
				rd_active <= 1'b1;
				rd_beat   <= 3'd0;
				rd_base   <= {ba, open_row[ba], addr[8:0]};
			end
			WRITE: begin
				if (!bank_open[ba])
					report_fault("WRITE to a bank that is not open");
				wkey = {ba, open_row[ba], addr[8:0]};
				old  = read_half(wkey);
				mem[wkey] = {dqm[1] ? old[15:8] : dq[15:8], dqm[0] ? old[7:0] : dq[7:0]};
			end
			AUTO_REFRESH: begin
				if (bank_open != 4'b0000)
					report_fault("AUTO_REFRESH with a bank still open");
				refresh_count++;
			end
			default: report_fault("unknown command on the pins");
			endcase
		end
	end

endmodule

// File: tb/sdram_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus side checker
// shadow memory, reference word and merge functions
// read data and ack count compares with error count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_checker import sdram_pkg::*; (
	input  logic        sd_clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [23:0] wb_adr,
	input  logic [3:0]  wb_sel,
	input  logic [2:0]  wb_cti,
	input  logic [31:0] wb_wdata,
	input  logic [31:0] wb_rdata,
	input  logic        wb_ack,
	output int          error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] shadow [logic [21:0]];	// word index adr[23:2]
	int          beat;	// acks seen in the current access
	logic        active, last_burst, is_burst;
	logic [31:0] exp_word;

	assign is_burst = (wb_cti == 3'b010) && !wb_we;

	// power-up contents of the chip, per half-word location
	function automatic logic [15:0] fill_pattern(input logic [22:0] key);
		return key[15:0] ^ {key[22:16], key[22:14]};
	endfunction

	// bank 22..21, row 20..9, column {23, 8..2, half}
	function automatic logic [22:0] chip_key(input logic [23:0] adr, input logic hi);
		return {adr[22:21], adr[20:9], adr[23], adr[8:2], hi};
	endfunction

	// word at burst position pos, wrapping inside the aligned line
	function automatic logic [31:0] expected_word(input logic [23:0] adr, input int pos);
		logic [23:0] a;
		a      = adr;
		a[3:2] = adr[3:2] + 2'(pos);
		if (shadow.exists(a[23:2]))
			return shadow[a[23:2]];
		return {fill_pattern(chip_key(a, 1'b1)), fill_pattern(chip_key(a, 1'b0))};
	endfunction

	function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] wdata,
			input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				res[8*b +: 8] = wdata[8*b +: 8];
		return res;
	endfunction

	initial begin
		error_count = 0;
		beat        = 0;
		active      = 1'b0;
		last_burst  = 1'b0;
	end

	always @(posedge sd_clk) begin
		if (reset) begin
			active = 1'b0;
			beat   = 0;
		end else if (wb_cyc && wb_stb) begin
			active     = 1'b1;
			last_burst = is_burst;
			if (wb_ack) begin
				exp_word = expected_word(wb_adr, beat);
				if (wb_we) begin
					shadow[wb_adr[23:2]] = merge_write(exp_word, wb_wdata, wb_sel);
				end else if (wb_rdata !== exp_word) begin
					$display("ERR %0t wb_rdata expected %h got %h", $time, exp_word, wb_rdata);
					error_count++;
				end
				beat++;
			end else if (beat != 0 && beat < 4 && is_burst) begin
				$display("%0t checker: gap in the burst acks at %h", $time, wb_adr);
				error_count++;
			end
		end else begin
			if (wb_ack) begin
				$display("%0t checker: ack without a request", $time);
				error_count++;
			end
			if (active && beat != (last_burst ? 4 : 1)) begin
				$display("ERR %0t wb_ack count expected %0d got %0d", $time,
					last_burst ? 4 : 1, beat);
				error_count++;
			end
			active = 1'b0;
			beat   = 0;
		end
	end

endmodule

// File: tb/tb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sdram controller testbench top
// dut, sdram model, checker and clock source
// bus stimulus on falling edges, watchdog, final summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_top import sdram_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SEED         = 14;
	localparam int PERIOD       = 4;
	localparam int N_WORDS      = 16;
	localparam int N_BURSTS     = 8;
	localparam int N_ROW_TESTS  = 12;
	localparam int IDLE_CYCLES  = 2000;
	localparam int ACK_LIMIT    = 200;	// cycles an access may take
	localparam int NUM_ACCESSES = 2 * N_WORDS + N_BURSTS + 2 * N_ROW_TESTS + 9;

	logic        sd_clk, reset, sd_cke, sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n, sd_ready;
	logic [1:0]  sd_ba, sd_dqm;
	logic [12:0] sd_addr;
	wire  [15:0] sd_dq;
	logic        wb_cyc, wb_stb, wb_we, wb_ack;
	logic [23:0] wb_adr;
	logic [3:0]  wb_sel;
	logic [2:0]  wb_cti;
	logic [31:0] wb_wdata, wb_rdata;
	logic        init_done;
	int          model_errors, checker_errors, tb_errors, refresh_count, rfsh_start, waited;
	logic [23:0] addrs [N_WORDS];
	logic [23:0] a;

	tb_clock u_clk (.sd_clk, .reset);

	sdram_top uut (.*);

	sdram_model u_model (
		.sd_clk, .reset, .cke(sd_cke), .cs_n(sd_cs_n), .ras_n(sd_ras_n), .cas_n(sd_cas_n),
		.we_n(sd_we_n), .ba(sd_ba), .addr(sd_addr), .dqm(sd_dqm), .dq(sd_dq), .init_done,
		.error_count(model_errors), .refresh_count
	);

	sdram_checker u_chk (
		.sd_clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_cti, .wb_wdata,
		.wb_rdata, .wb_ack, .error_count(checker_errors)
	);

	// word address from chip coordinates, low two bits unused
	function automatic logic [23:0] make_adr(input logic [1:0] bank, input logic [11:0] row,
			input logic [7:0] col);
		return {col[7], bank, row, col[6:0], 2'b00};
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic bus_access(input logic we, input logic [23:0] adr, input logic [31:0] wdata,
			input logic [3:0] sel, input logic burst);
		int acks;
		int cycles;
		int want;
		acks   = 0;
		cycles = 0;
		want   = burst ? 4 : 1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_wdata = wdata;
		wb_sel   = sel;
		wb_cti   = burst ? 3'b010 : 3'b000;
		while (acks < want && cycles < ACK_LIMIT) begin
			@(posedge sd_clk);
			if (wb_ack)
				acks++;
			cycles++;
		end
		if (acks < want) begin
			$display("%0t access to %h got %0d of %0d acks", $time, adr, acks, want);
			tb_errors++;
		end
		@(negedge sd_clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		wb_cti = 3'b000;
		@(negedge sd_clk);
	endtask

	initial begin
		#(PERIOD * (INIT_WAIT + 3 * MRS_GAP + ACK_LIMIT * NUM_ACCESSES + IDLE_CYCLES) * 2);
		$display("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		tb_errors = 0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_sel    = '0;
		wb_cti    = '0;
		wb_wdata  = '0;
		@(negedge reset);
		waited = 0;
		while (!sd_ready && waited < INIT_WAIT + 4 * MRS_GAP) begin
			@(negedge sd_clk);
			waited++;
		end
		if (!sd_ready) begin
			$display("sd_ready never rose after reset");
			tb_errors++;
		end else if (!init_done) begin
			$display("sd_ready rose before the model saw the init sequence");
			tb_errors++;
		end
		// random writes with byte selects, then read back
		for (int i = 0; i < N_WORDS; i++) begin
			addrs[i] = 24'($urandom) & 24'hfffffc;
			bus_access(1'b1, addrs[i], $urandom, 4'($urandom), 1'b0);
		end
		for (int i = 0; i < N_WORDS; i++)
			bus_access(1'b0, addrs[i], '0, 4'hf, 1'b0);
		// wrapping bursts from random words of written lines
		for (int i = 0; i < N_BURSTS; i++) begin
			a      = addrs[$urandom % N_WORDS];
			a[3:2] = 2'($urandom);
			bus_access(1'b0, a, '0, 4'hf, 1'b1);
		end
		// closed, hit and miss rows in and across banks
		for (int i = 0; i < N_ROW_TESTS; i++) begin
			a = make_adr(2'(i % 3), (i % 2 == 1) ? 12'h0a5 : 12'h3c0, 8'(i * 4));
			bus_access(1'b1, a, $urandom, 4'hf, 1'b0);
			bus_access(1'b0, a, '0, 4'hf, 1'b0);
		end
		// line buffer hit, then invalidate by a write
		a = make_adr(2'd3, 12'h123, 8'h40);
		bus_access(1'b0, a, '0, 4'hf, 1'b0);
		bus_access(1'b0, a + 24'd4, '0, 4'hf, 1'b0);
		bus_access(1'b1, a + 24'd4, $urandom, 4'hf, 1'b0);
		bus_access(1'b0, a + 24'd4, '0, 4'hf, 1'b0);
		bus_access(1'b0, a, '0, 4'hf, 1'b0);
		// long idle, refresh only
		rfsh_start = refresh_count;
		repeat (IDLE_CYCLES) @(negedge sd_clk);
		if (refresh_count - rfsh_start < IDLE_CYCLES / (REFRESH_PERIOD + 20)) begin
			$display("only %0d refreshes in %0d idle cycles", refresh_count - rfsh_start,
				IDLE_CYCLES);
			tb_errors++;
		end
		for (int i = 0; i < 4; i++)
			bus_access(1'b0, addrs[i], '0, 4'hf, 1'b0);
		repeat (4) @(negedge sd_clk);
		$display("errors: checker %0d, model %0d, testbench %0d", checker_errors,
			model_errors, tb_errors);
		if (checker_errors + model_errors + tb_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: build.f
design/sdram_pkg.sv
design/sdram_row_tracker.sv
design/sdram_refresh_timer.sv
design/sdram_line_buffer.sv
design/sdram_sequencer.sv
design/sdram_top.sv
tb/tb_clock.sv
tb/sdram_model.sv
tb/sdram_checker.sv
tb/tb_top.sv

// File: Makefile
# Verilator build and run of the SDRAM controller testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = build.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
